// File: rtl/matrix_div_pkg.sv
/* Shared types for the matrix divider. Operands are unsigned, DATA_W bits wide.
   Every level passes the same operand pair and result structs. */

package matrix_div_pkg;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // Operand width, fixed here so the structs have a known size
  localparam int DATA_W = 16;

  ////////////////////////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////////////////////////

  // One element pair, A over B
  typedef struct packed {
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
  } div_operands_t;

  // Quotient and remainder of one pair
  typedef struct packed {
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;
  } div_result_t;

  ////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle    = 2'd0,
    collect = 2'd1,
    divide  = 2'd2
  } div_ctrl_state_t;

endpackage

// File: rtl/scalar_int_divider.sv
/* Iterative unsigned restoring divider, one quotient bit per cycle.
   done follows start by DATA_W + 1 cycles; start while busy is not allowed.
   A zero divisor gives an all-ones quotient and the dividend as remainder. */

module scalar_int_divider
  import matrix_div_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,
  input  logic          start,
  input  div_operands_t operands,
  output logic          done,
  output div_result_t   result
);

  localparam int CNT_W = $clog2(DATA_W + 1);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic              busy;
  logic [CNT_W-1:0]  steps_left;
  logic [DATA_W-1:0] divisor_q;
  logic [DATA_W-1:0] quo_q;
  logic [DATA_W-1:0] rem_q;

  // Partial remainder with next dividend bit shifted in
  logic [DATA_W:0]   shifted;
  // Trial subtraction with the borrow in the MSB
  logic [DATA_W:0]   trial;

  assign shifted = {rem_q, quo_q[DATA_W-1]};
  assign trial   = shifted - {1'b0, divisor_q};

  ////////////////////////////////////////////////////////////
  // Step control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      steps_left <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        // Load cycle then DATA_W shift steps
        busy       <= 1'b1;
        steps_left <= CNT_W'(DATA_W);
      end else if (busy) begin
        steps_left <= steps_left - 1'b1;
        // Last step so the result is final on the next cycle
        if (steps_left == CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Quotient register doubles as dividend shift register
  always_ff @(posedge CLK) begin
    if (start && !busy) begin
      divisor_q <= operands.divisor;
      quo_q     <= operands.dividend;
      rem_q     <= '0;
    end else if (busy) begin
      if (!trial[DATA_W]) begin
        // Divisor fits so keep the difference
        rem_q <= trial[DATA_W-1:0];
        quo_q <= {quo_q[DATA_W-2:0], 1'b1};
      end else begin
        // Restore the shifted remainder
        rem_q <= shifted[DATA_W-1:0];
        quo_q <= {quo_q[DATA_W-2:0], 1'b0};
      end
    end
  end

  // Valid while done is high and until the next load
  assign result = '{quotient: quo_q, remainder: rem_q};

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Feeder must wait for done before the next pair
  a_no_start_busy: assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
    else $error("scalar divider started while busy");

  // Load cycle plus DATA_W steps before done
  a_done_latency: assert property (@(posedge CLK) disable iff (RST)
    (start && !busy) |-> ##(DATA_W + 1) done)
    else $error("done did not arrive DATA_W + 1 cycles after start");

endmodule

// File: rtl/vector_int_divider.sv
/* Row sequencer around one scalar divider: one input and one output register stage.
   Only one pair may be outstanding; row_start must mark column 0 of each row. */

module vector_int_divider
  import matrix_div_pkg::*;
#(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    op_valid,
  input  logic                    row_start,
  input  logic [CONTROL_SIZE-1:0] size_j,
  input  div_operands_t           operands,
  output logic                    result_valid,
  output logic                    row_last,
  output div_result_t             result
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  div_operands_t           op_q;
  logic                    div_start;
  logic                    div_done;
  div_result_t             div_result;

  // One pair in flight
  logic                    busy;
  // Column of the pair in flight
  logic [CONTROL_SIZE-1:0] col_q;
  logic                    accept;

  assign accept = op_valid && !busy;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      div_start    <= 1'b0;
      busy         <= 1'b0;
      col_q        <= '0;
      result_valid <= 1'b0;
      row_last     <= 1'b0;
    end else begin
      div_start    <= accept;
      result_valid <= div_done;
      // Last column flagged alongside the result
      row_last     <= div_done && (col_q == size_j - 1'b1);
      if (accept) begin
        busy  <= 1'b1;
        col_q <= row_start ? '0 : col_q + 1'b1;
      end else if (div_done) begin
        busy <= 1'b0;
      end
    end
  end

  // Input and output payload stages
  always_ff @(posedge CLK) begin
    if (accept) begin
      op_q <= operands;
    end
    if (div_done) begin
      result <= div_result;
    end
  end

  scalar_int_divider scalar_int_divider_inst (
    .CLK     (CLK),
    .RST     (RST),
    .start   (div_start),
    .operands(op_q),
    .done    (div_done),
    .result  (div_result)
  );

  // Controller must not issue a pair before the previous result
  a_no_overlap: assert property (@(posedge CLK) disable iff (RST) op_valid |-> !busy)
    else $error("operand pair issued while a division is outstanding");

endmodule

// File: rtl/matrix_int_divider.sv
/* Element-wise unsigned matrix divider, row-major, no back-pressure.
   Sizes are sampled on start and must be nonzero; one element in flight at a time.
   Latency from the later operand strobe to data_out_enable is DATA_W + 4 cycles. */

module matrix_int_divider
  import matrix_div_pkg::*;
#(
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  logic [CONTROL_SIZE-1:0] size_i,
  input  logic [CONTROL_SIZE-1:0] size_j,
  input  logic                    data_a_in_enable,
  input  logic                    data_b_in_enable,
  input  logic [DATA_W-1:0]       data_a_in,
  input  logic [DATA_W-1:0]       data_b_in,
  output logic                    data_out_enable,
  output logic                    row_end,
  output logic                    ready,
  output div_result_t             result
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  div_ctrl_state_t         state;

  // Sizes latched on start
  logic [CONTROL_SIZE-1:0] size_i_q;
  logic [CONTROL_SIZE-1:0] size_j_q;
  // Current element position
  logic [CONTROL_SIZE-1:0] row_q;
  logic [CONTROL_SIZE-1:0] col_q;

  logic [DATA_W-1:0]       a_q;
  logic [DATA_W-1:0]       b_q;
  logic                    held_a;
  logic                    held_b;
  // Held already or arriving this cycle
  logic                    a_now;
  logic                    b_now;

  logic                    op_valid;
  logic                    row_start;
  div_operands_t           operands;
  logic                    vec_valid;
  logic                    vec_row_last;
  div_result_t             vec_result;

  assign a_now     = held_a | data_a_in_enable;
  assign b_now     = held_b | data_b_in_enable;
  assign operands  = '{dividend: a_q, divisor: b_q};
  assign row_start = (col_q == '0);

  ////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= idle;
      size_i_q        <= '0;
      size_j_q        <= '0;
      row_q           <= '0;
      col_q           <= '0;
      held_a          <= 1'b0;
      held_b          <= 1'b0;
      op_valid        <= 1'b0;
      data_out_enable <= 1'b0;
      row_end         <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Strobes default low
      op_valid        <= 1'b0;
      data_out_enable <= 1'b0;
      row_end         <= 1'b0;
      ready           <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            row_q    <= '0;
            col_q    <= '0;
            held_a   <= 1'b0;
            held_b   <= 1'b0;
            state    <= collect;
          end
        end
        collect: begin
          if (data_a_in_enable) begin
            held_a <= 1'b1;
          end
          if (data_b_in_enable) begin
            held_b <= 1'b1;
          end
          // Both halves present, hand the pair down
          if (a_now && b_now) begin
            held_a   <= 1'b0;
            held_b   <= 1'b0;
            op_valid <= 1'b1;
            state    <= divide;
          end
        end
        divide: begin
          if (vec_valid) begin
            data_out_enable <= 1'b1;
            row_end         <= vec_row_last;
            if (vec_row_last) begin
              col_q <= '0;
              // Last row done, matrix complete
              if (row_q == size_i_q - 1'b1) begin
                ready <= 1'b1;
                state <= idle;
              end else begin
                row_q <= row_q + 1'b1;
                state <= collect;
              end
            end else begin
              col_q <= col_q + 1'b1;
              state <= collect;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////////////////////////

  // First strobe of each operand wins
  always_ff @(posedge CLK) begin
    if (state == collect && data_a_in_enable && !held_a) begin
      a_q <= data_a_in;
    end
    if (state == collect && data_b_in_enable && !held_b) begin
      b_q <= data_b_in;
    end
    if (state == divide && vec_valid) begin
      result <= vec_result;
    end
  end

  vector_int_divider #(
    .CONTROL_SIZE(CONTROL_SIZE)
  ) vector_int_divider_inst (
    .CLK         (CLK),
    .RST         (RST),
    .op_valid    (op_valid),
    .row_start   (row_start),
    .size_j      (size_j_q),
    .operands    (operands),
    .result_valid(vec_valid),
    .row_last    (vec_row_last),
    .result      (vec_result)
  );

  // Zero sizes would never reach a row or matrix end
  a_size_nonzero: assert property (@(posedge CLK) disable iff (RST)
    (state == idle && start) |-> (size_i != '0 && size_j != '0))
    else $error("start accepted with a zero matrix size");

endmodule

// File: tests/tb_clock_gen.sv
/* Testbench clock with period 20 and reset held high for 2 rising edges. */

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Release on an edge so the first active cycle is a full one
  initial begin
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

// File: tests/tb_checker.sv
/* Watches the DUT outputs and compares each result strobe with the next expected entry.
   Outputs are sampled on the rising edge, before that edge's register updates. */

module tb_checker
  import matrix_div_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        data_out_enable,
  input  logic        row_end,
  input  logic        ready,
  input  div_result_t result,
  output logic [31:0] cycle
);

  // One expected output strobe
  typedef struct packed {
    div_result_t res;
    logic        row_end;
    logic        ready;
    logic [31:0] due;
  } expect_t;

  expect_t pending[$];
  int      error_count;
  int      result_count;
  int      ready_count;

  initial begin
    error_count  = 0;
    result_count = 0;
    ready_count  = 0;
  end

  // Shared cycle index that the stimulus side also reads
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      cycle <= '0;
    end else begin
      cycle <= cycle + 1'b1;
    end
  end

  task automatic expect_result(input div_result_t res, input logic row_end_exp,
                               input logic ready_exp, input logic [31:0] due);
    pending.push_back('{res: res, row_end: row_end_exp, ready: ready_exp, due: due});
  endtask

  task automatic check_field(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error @%0t: %s = %0d, expected %0d", $time, name, got, exp);
      error_count = error_count + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin : compare
    expect_t head;
    if (!RST) begin
      if (data_out_enable) begin
        result_count = result_count + 1;
        if (ready) begin
          ready_count = ready_count + 1;
        end
        if (pending.size() == 0) begin
          $display("** Error @%0t: data_out_enable = 1, expected 0", $time);
          error_count = error_count + 1;
        end else begin
          head = pending.pop_front();
          check_field("result.quotient", result.quotient, head.res.quotient);
          check_field("result.remainder", result.remainder, head.res.remainder);
          check_field("row_end", row_end, head.row_end);
          check_field("ready", ready, head.ready);
          // Latency seen as the sample cycle of the strobe
          if (cycle != head.due) begin
            $display("** Error @%0t: data_out_enable cycle = %0d, expected %0d",
                     $time, cycle, head.due);
            error_count = error_count + 1;
          end
        end
      end else if (row_end || ready) begin
        $display("Error @%0t: row_end or ready raised without data_out_enable", $time);
        error_count = error_count + 1;
      end
    end
  end

  // End of run totals
  task automatic final_check(input int exp_results, input int exp_readys);
    if (pending.size() != 0) begin
      $display("Error: %0d expected results never arrived", pending.size());
      error_count = error_count + 1;
    end
    if (result_count != exp_results) begin
      $display("Error: saw %0d results instead of %0d", result_count, exp_results);
      error_count = error_count + 1;
    end
    if (ready_count != exp_readys) begin
      $display("Error: saw %0d ready pulses instead of %0d", ready_count, exp_readys);
      error_count = error_count + 1;
    end
  endtask

endmodule

// File: tests/tb_matrix_int_divider.sv
/* Testbench top: applies the matrix case table one element at a time.
   Each pair waits for its result strobe; random rows come from a fixed seed. */

module tb_matrix_int_divider
  import matrix_div_pkg::*;
();

  localparam int CONTROL_SIZE = 8;
  localparam int NUM_CASES    = 4;
  localparam int NUM_ELEMS    = 17;
  localparam int LATENCY      = DATA_W + 4;
  localparam int CYCLE_LIMIT  = NUM_ELEMS * (DATA_W + 10) + 100;

  logic                    CLK;
  logic                    RST;
  logic                    start;
  logic [CONTROL_SIZE-1:0] size_i;
  logic [CONTROL_SIZE-1:0] size_j;
  logic                    data_a_in_enable;
  logic                    data_b_in_enable;
  logic [DATA_W-1:0]       data_a_in;
  logic [DATA_W-1:0]       data_b_in;
  logic                    data_out_enable;
  logic                    row_end;
  logic                    ready;
  div_result_t             result;
  logic [31:0]             cycle;
  int                      timeout_cycles;

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  int            case_rows   [NUM_CASES];
  int            case_cols   [NUM_CASES];
  // Positive means A leads B by that many cycles
  int            case_offset [NUM_CASES];
  logic          case_noise  [NUM_CASES];
  div_operands_t elem_op     [NUM_ELEMS];
  div_result_t   elem_exp    [NUM_ELEMS];

  // Unsigned division where a zero divisor gives all ones and the dividend back
  function automatic div_result_t reference_divide(input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
    div_result_t res;
    if (b == '0) begin
      res.quotient  = '1;
      res.remainder = a;
    end else begin
      res.quotient  = a / b;
      res.remainder = a % b;
    end
    return res;
  endfunction

  task automatic set_case(input int idx, input int rows, input int cols,
                          input int offset, input logic noise);
    case_rows[idx]   = rows;
    case_cols[idx]   = cols;
    case_offset[idx] = offset;
    case_noise[idx]  = noise;
  endtask

  task automatic set_elem(input int idx, input logic [DATA_W-1:0] a, b, q, r);
    elem_op[idx]  = '{dividend: a, divisor: b};
    elem_exp[idx] = '{quotient: q, remainder: r};
  endtask

  task automatic load_tables();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    set_case(0, 1, 1, 0, 1'b0);
    set_case(1, 1, 4, 2, 1'b0);
    set_case(2, 3, 1, -1, 1'b0);
    set_case(3, 3, 3, 0, 1'b1);
    set_elem(0, 100, 7, 14, 2);
    // Small dividend, maximal values, divide by zero
    set_elem(1, 5, 9, 0, 5);
    set_elem(2, 16'hffff, 1, 16'hffff, 0);
    set_elem(3, 16'hffff, 16'hffff, 1, 0);
    set_elem(4, 1234, 0, 16'hffff, 1234);
    set_elem(5, 0, 0, 16'hffff, 0);
    set_elem(6, 40000, 3, 13333, 1);
    set_elem(7, 16'hfffe, 16'hffff, 0, 16'hfffe);
    // Random 3x3 block with small divisors for larger quotients
    for (int i = 8; i < NUM_ELEMS; i++) begin
      a = DATA_W'($urandom);
      b = DATA_W'($urandom % 300);
      elem_op[i]  = '{dividend: a, divisor: b};
      elem_exp[i] = reference_divide(a, b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drive tasks
  ////////////////////////////////////////////////////////////

  task automatic start_matrix(input int rows, input int cols);
    @(posedge CLK);
    start  <= 1'b1;
    size_i <= CONTROL_SIZE'(rows);
    size_j <= CONTROL_SIZE'(cols);
    @(posedge CLK);
    start  <= 1'b0;
  endtask

  // Returns the cycle index read on the edge that drives the later strobe
  task automatic drive_pair(input div_operands_t op, input int offset,
                            output logic [31:0] issue);
    @(posedge CLK);
    data_a_in <= op.dividend;
    data_b_in <= op.divisor;
    if (offset >= 0) begin
      data_a_in_enable <= 1'b1;
    end
    if (offset <= 0) begin
      data_b_in_enable <= 1'b1;
    end
    if (offset != 0) begin
      repeat ((offset > 0) ? offset : -offset) begin
        @(posedge CLK);
        data_a_in_enable <= 1'b0;
        data_b_in_enable <= 1'b0;
      end
      // Later NBA wins over the clear above
      if (offset > 0) begin
        data_b_in_enable <= 1'b1;
      end else begin
        data_a_in_enable <= 1'b1;
      end
    end
    issue = cycle;
  endtask

  task automatic release_strobes();
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
  endtask

  // Junk operands and a restart in the middle of a division
  task automatic inject_noise();
    repeat (4) @(posedge CLK);
    data_a_in_enable <= 1'b1;
    data_b_in_enable <= 1'b1;
    data_a_in        <= 16'hdead;
    data_b_in        <= 16'h0001;
    start            <= 1'b1;
    size_i           <= CONTROL_SIZE'(1);
    size_j           <= CONTROL_SIZE'(1);
    @(posedge CLK);
    data_a_in_enable <= 1'b0;
    data_b_in_enable <= 1'b0;
    start            <= 1'b0;
  endtask

  task automatic wait_output();
    do begin
      @(posedge CLK);
    end while (data_out_enable !== 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  tb_clock_gen clock_gen_inst (
    .CLK(CLK),
    .RST(RST)
  );

  matrix_int_divider #(
    .CONTROL_SIZE(CONTROL_SIZE)
  ) matrix_int_divider_inst (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size_i          (size_i),
    .size_j          (size_j),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .data_out_enable (data_out_enable),
    .row_end         (row_end),
    .ready           (ready),
    .result          (result)
  );

  tb_checker checker_inst (
    .CLK            (CLK),
    .RST            (RST),
    .data_out_enable(data_out_enable),
    .row_end        (row_end),
    .ready          (ready),
    .result         (result),
    .cycle          (cycle)
  );

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed;
    logic [31:0] issue;
    int          e;
    start            = 1'b0;
    size_i           = '0;
    size_j           = '0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    data_a_in        = '0;
    data_b_in        = '0;
    seed             = 32'h2008f683;
    void'($urandom(seed));
    load_tables();
    @(negedge RST);

    // Operands before any start must produce nothing
    @(posedge CLK);
    data_a_in_enable <= 1'b1;
    data_b_in_enable <= 1'b1;
    data_a_in        <= 16'h00ff;
    data_b_in        <= 16'h0003;
    release_strobes();
    repeat (LATENCY + 4) @(posedge CLK);

    e = 0;
    for (int k = 0; k < NUM_CASES; k++) begin
      start_matrix(case_rows[k], case_cols[k]);
      for (int r = 0; r < case_rows[k]; r++) begin
        for (int c = 0; c < case_cols[k]; c++) begin
          drive_pair(elem_op[e], case_offset[k], issue);
          // Capture edge, LATENCY edges to the strobe, one more to sample it
          checker_inst.expect_result(elem_exp[e], c == case_cols[k] - 1,
                                     (r == case_rows[k] - 1) && (c == case_cols[k] - 1),
                                     issue + LATENCY + 2);
          release_strobes();
          if (case_noise[k]) begin
            inject_noise();
          end
          wait_output();
          e = e + 1;
        end
      end
    end

    repeat (4) @(posedge CLK);
    checker_inst.final_check(NUM_ELEMS, NUM_CASES);
    $display("Checks done: %0d errors, %0d results, %0d ready pulses",
             checker_inst.error_count, checker_inst.result_count,
             checker_inst.ready_count);
    if (checker_inst.error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Hang guard
  initial begin
    timeout_cycles = 0;
    while (timeout_cycles < CYCLE_LIMIT) begin
      @(posedge CLK);
      timeout_cycles = timeout_cycles + 1;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("sim failed");
    $finish;
  end

endmodule

// File: verilog.f
rtl/matrix_div_pkg.sv
rtl/scalar_int_divider.sv
rtl/vector_int_divider.sv
rtl/matrix_int_divider.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_matrix_int_divider.sv

// File: Bender.yml
package:
  name: matrix_int_divider

sources:
  - rtl/matrix_div_pkg.sv
  - rtl/scalar_int_divider.sv
  - rtl/vector_int_divider.sv
  - rtl/matrix_int_divider.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_checker.sv
      - tests/tb_matrix_int_divider.sv
